// File: common/dcache_cfg_pkg.sv
// ==========================================================
// L1 data cache geometry
// Address split and storage widths for the 4-way cache
// ==========================================================

package dcache_cfg_pkg;

	// Address split  tag | set | byte offset
	localparam int ADDR_W   = 32;
	localparam int OFFSET_W = 6;	// 64-byte line
	localparam int SET_W    = 4;	// 16 sets
	localparam int TAG_W    = 22;

	// Data path
	localparam int WORD_W         = 32;
	localparam int WORDS_PER_LINE = 16;
	localparam int LINE_W         = 512;

	// Associativity
	localparam int NUM_WAYS = 4;
	localparam int WAY_W    = 2;

endpackage

// File: common/dcache_types_pkg.sv
// ==========================================================
// L1 data cache stored data types
// Line view and tag status encoding
// ==========================================================

package dcache_types_pkg;

	import dcache_cfg_pkg::*;

	// One cache line, seen flat when written and as words when read
	typedef union packed {
		logic [LINE_W-1:0] flat;
		logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;	// Word 0 at bits 31:0
	} line_u;

	// Per-entry age, higher is more recently used
	localparam int STATUS_W = 2;

	localparam logic [STATUS_W-1:0] ST_INVALID = 2'd0;
	localparam logic [STATUS_W-1:0] ST_FLOOR   = 2'd1;	// Ageing stops here
	localparam logic [STATUS_W-1:0] ST_NEWEST  = 2'd3;

endpackage

// File: dcache/dcache_tag_store.sv
// ==========================================================
// L1 data cache tag store
// Tag and status arrays, read lookup, write way choice,
// timer based status ageing and whole-cache remove
// ==========================================================

`timescale 1ns/1ps

module dcache_tag_store
	import dcache_cfg_pkg::*;
	import dcache_types_pkg::*;
#(
	parameter int LRU_TIMER_W = 16
) (
	input  logic             iCLOCK,
	input  logic             inRESET,
	input  logic             remove,
	input  logic             advance,
	input  logic             rd_req,
	input  logic [ADDR_W-1:0] rd_addr,
	input  logic             wr_req,
	input  logic [ADDR_W-1:0] wr_addr,
	output logic             lookup_hit,
	output logic [WAY_W-1:0] lookup_way,
	output logic [WAY_W-1:0] wr_way
);

	logic [TAG_W-1:0]    tag_mem  [NUM_WAYS][2**SET_W];	// Address tags
	logic [STATUS_W-1:0] status_q [NUM_WAYS][2**SET_W];	// 0 means invalid

	logic [SET_W-1:0]       rd_set;
	logic [TAG_W-1:0]       rd_tag;
	logic [SET_W-1:0]       wr_set;
	logic [TAG_W-1:0]       wr_tag;
	logic                   wr_found;
	logic [LRU_TIMER_W-1:0] lru_timer;
	logic                   age_due;

	assign rd_set = rd_addr[OFFSET_W +: SET_W];
	assign rd_tag = rd_addr[ADDR_W-1 -: TAG_W];
	assign wr_set = wr_addr[OFFSET_W +: SET_W];
	assign wr_tag = wr_addr[ADDR_W-1 -: TAG_W];

	// Read hit, lowest matching valid way wins
	always_comb begin
		lookup_hit = 1'b0;
		lookup_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (!lookup_hit && status_q[w][rd_set] != ST_INVALID &&
					tag_mem[w][rd_set] == rd_tag) begin
				lookup_hit = 1'b1;
				lookup_way = WAY_W'(w);
			end
		end
	end

	// Write way: same tag first, then the oldest status, lowest way first.
	// A stale tag on an invalid way still counts as a match.
	always_comb begin
		wr_found = 1'b0;
		wr_way   = WAY_W'(NUM_WAYS - 1);	// All ways newest
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (!wr_found && tag_mem[w][wr_set] == wr_tag) begin
				wr_found = 1'b1;
				wr_way   = WAY_W'(w);
			end
		end
		for (int lvl = 0; lvl < int'(ST_NEWEST); lvl++) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (!wr_found && status_q[w][wr_set] == STATUS_W'(lvl)) begin
					wr_found = 1'b1;
					wr_way   = WAY_W'(w);
				end
			end
		end
	end

	// Ageing timer, frozen under hold
	assign age_due = &lru_timer;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			lru_timer <= '0;
		end else if (remove) begin
			lru_timer <= '0;
		end else if (advance) begin
			lru_timer <= lru_timer + 1'b1;
		end
	end

	// Tag field only changes on a line write
	always_ff @(posedge iCLOCK) begin
		if (wr_req) begin
			tag_mem[wr_way][wr_set] <= wr_tag;
		end
	end

	// Status update
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				for (int s = 0; s < 2**SET_W; s++) begin
					status_q[w][s] <= ST_INVALID;
				end
			end
		end else if (remove) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				for (int s = 0; s < 2**SET_W; s++) begin
					status_q[w][s] <= ST_INVALID;
				end
			end
		end else if (wr_req) begin
			status_q[wr_way][wr_set] <= ST_NEWEST;	// Write beats read and ageing
		end else if (advance) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				for (int s = 0; s < 2**SET_W; s++) begin
					if (rd_req && lookup_hit && lookup_way == WAY_W'(w) &&
							rd_set == SET_W'(s)) begin
						status_q[w][s] <= ST_NEWEST;	// Hit entry refreshed
					end else if (age_due && status_q[w][s] > ST_FLOOR) begin
						status_q[w][s] <= status_q[w][s] - 1'b1;
					end
				end
			end
		end
	end

endmodule

// File: dcache/dcache_way_ram.sv
// ==========================================================
// L1 data cache way RAM
// Line storage for all ways, whole-line write and
// registered read of every way at the read set
// ==========================================================

`timescale 1ns/1ps

module dcache_way_ram
	import dcache_cfg_pkg::*;
	import dcache_types_pkg::*;
(
	input  logic                       iCLOCK,
	input  logic                       advance,
	input  logic [SET_W-1:0]           rd_set,
	input  logic                       wr_req,
	input  logic [SET_W-1:0]           wr_set,
	input  logic [WAY_W-1:0]           wr_way,
	input  line_u                      wr_line,
	output line_u [NUM_WAYS-1:0]       way_lines
);

	// One line array per way
	line_u line_mem [NUM_WAYS][2**SET_W];

	// Whole-line write into the chosen way
	always_ff @(posedge iCLOCK) begin
		if (wr_req) begin
			line_mem[wr_way][wr_set] <= wr_line;
		end
	end

	// All ways read in parallel, way picked later by the read port.
	// A write in the same cycle is not seen by this read.
	always_ff @(posedge iCLOCK) begin
		if (advance) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				way_lines[w] <= line_mem[w][rd_set];
			end
		end
	end

endmodule

// File: dcache/dcache_read_port.sv
// ==========================================================
// L1 data cache read port
// Request register, word select, output gating and stall
// ==========================================================

`timescale 1ns/1ps

module dcache_read_port
	import dcache_cfg_pkg::*;
	import dcache_types_pkg::*;
(
	input  logic                 iCLOCK,
	input  logic                 inRESET,
	input  logic                 remove,
	input  logic                 rd_req,
	input  logic                 rd_hold,
	input  logic [ADDR_W-1:0]    rd_addr,
	input  logic                 wr_req,
	input  logic [ADDR_W-1:0]    wr_addr,
	input  logic                 lookup_hit,
	input  logic [WAY_W-1:0]     lookup_way,
	input  line_u [NUM_WAYS-1:0] way_lines,
	output logic                 advance,
	output logic                 rd_stall,
	output logic                 rd_valid,
	output logic                 rd_hit,
	output logic [WORD_W-1:0]    rd_data
);

	localparam int BYTE_SEL_W = $clog2(WORD_W / 8);

	logic                             pending_q;
	logic                             hit_q;
	logic [WAY_W-1:0]                 way_q;
	logic [OFFSET_W-BYTE_SEL_W-1:0]   word_q;
	line_u                            sel_line;

	assign advance = !rd_hold;

	// Same tag and set being written this cycle
	assign rd_stall = rd_hold ||
		(rd_req && wr_req && rd_addr[ADDR_W-1:OFFSET_W] == wr_addr[ADDR_W-1:OFFSET_W]);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pending_q <= 1'b0;
		end else if (remove) begin
			pending_q <= 1'b0;	// Drop the read in flight
		end else if (advance) begin
			pending_q <= rd_req;
		end
	end

	// Lookup result travels alongside the RAM read
	always_ff @(posedge iCLOCK) begin
		if (advance) begin
			hit_q  <= lookup_hit;
			way_q  <= lookup_way;
			word_q <= rd_addr[OFFSET_W-1:BYTE_SEL_W];
		end
	end

	assign sel_line = way_lines[way_q];

	assign rd_valid = pending_q && !rd_hold;
	assign rd_hit   = rd_valid && hit_q;
	assign rd_data  = rd_hit ? sel_line.words[word_q] : '0;	// Zero on miss

endmodule

// File: dcache/l1_dcache.sv
// ==========================================================
// L1 data cache top level
// 4-way, 16 sets, 64-byte lines, whole-line fill and
// single-word reads with one cycle latency
// ==========================================================

`timescale 1ns/1ps

module l1_dcache
	import dcache_cfg_pkg::*;
	import dcache_types_pkg::*;
#(
	parameter int LRU_TIMER_W = 16
) (
	input  logic              iCLOCK,
	input  logic              inRESET,
	input  logic              remove,
	input  logic              rd_req,
	input  logic [ADDR_W-1:0] rd_addr,
	output logic              rd_stall,
	output logic              rd_valid,
	output logic              rd_hit,
	output logic [WORD_W-1:0] rd_data,
	input  logic              rd_hold,
	input  logic              wr_req,
	input  logic [ADDR_W-1:0] wr_addr,
	input  line_u             wr_line
);

	logic                 advance;
	logic                 lookup_hit;
	logic [WAY_W-1:0]     lookup_way;
	logic [WAY_W-1:0]     wr_way;
	line_u [NUM_WAYS-1:0] way_lines;

	dcache_tag_store #(
		.LRU_TIMER_W (LRU_TIMER_W)
	) i_tag_store (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.remove     (remove),
		.advance    (advance),
		.rd_req     (rd_req),
		.rd_addr    (rd_addr),
		.wr_req     (wr_req),
		.wr_addr    (wr_addr),
		.lookup_hit (lookup_hit),
		.lookup_way (lookup_way),
		.wr_way     (wr_way)
	);

	dcache_way_ram i_way_ram (
		.iCLOCK    (iCLOCK),
		.advance   (advance),
		.rd_set    (rd_addr[OFFSET_W +: SET_W]),
		.wr_req    (wr_req),
		.wr_set    (wr_addr[OFFSET_W +: SET_W]),
		.wr_way    (wr_way),
		.wr_line   (wr_line),
		.way_lines (way_lines)
	);

	dcache_read_port i_read_port (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.remove     (remove),
		.rd_req     (rd_req),
		.rd_hold    (rd_hold),
		.rd_addr    (rd_addr),
		.wr_req     (wr_req),
		.wr_addr    (wr_addr),
		.lookup_hit (lookup_hit),
		.lookup_way (lookup_way),
		.way_lines  (way_lines),
		.advance    (advance),
		.rd_stall   (rd_stall),
		.rd_valid   (rd_valid),
		.rd_hit     (rd_hit),
		.rd_data    (rd_data)
	);

endmodule

// File: bench/l1_dcache_sva.sv
// ==========================================================
// L1 data cache port assertions
// Output gating rules of the read result
// ==========================================================

`timescale 1ns/1ps

module l1_dcache_sva
	import dcache_cfg_pkg::*;
(
	input logic              iCLOCK,
	input logic              inRESET,
	input logic              remove,
	input logic              rd_hold,
	input logic              rd_valid,
	input logic              rd_hit,
	input logic [WORD_W-1:0] rd_data
);

	hit_needs_valid : assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rd_hit |-> rd_valid)
		else $error("rd_hit high without rd_valid");

	no_valid_under_hold : assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rd_hold |-> !rd_valid)
		else $error("rd_valid high while rd_hold is high");

	zero_data_on_miss : assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!rd_hit |-> rd_data == '0)
		else $error("rd_data not zero without rd_hit");

	remove_drops_read : assert property (@(posedge iCLOCK) disable iff (!inRESET)
		remove |=> !rd_valid)
		else $error("rd_valid high in the cycle after remove");

endmodule

bind l1_dcache l1_dcache_sva i_l1_dcache_sva (
	.iCLOCK   (iCLOCK),
	.inRESET  (inRESET),
	.remove   (remove),
	.rd_hold  (rd_hold),
	.rd_valid (rd_valid),
	.rd_hit   (rd_hit),
	.rd_data  (rd_data)
);

// File: bench/tb_l1_dcache.sv
// ==========================================================
// L1 data cache testbench
// Directed tests checked against a line reference model
// ==========================================================

`timescale 1ns/1ps

module tb_l1_dcache
	import dcache_cfg_pkg::*;
	import dcache_types_pkg::*;
();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 16;
	localparam int WAIT_LIMIT   = 8;	// Cycles allowed for rd_valid
	localparam int IDLE_CYCLES  = 64;	// Four ageing periods with a 4-bit timer
	localparam int LINE_ADDR_W  = ADDR_W - OFFSET_W;
	localparam int WORD_SEL_W   = OFFSET_W - 2;
	localparam int BUDGET_ALL   = RESET_CYCLES + 20 + 100 + 120 + 40 + 30 + 20;

	logic              iCLOCK;
	logic              inRESET;
	logic              remove;
	logic              rd_req;
	logic [ADDR_W-1:0] rd_addr;
	logic              rd_stall;
	logic              rd_valid;
	logic              rd_hit;
	logic [WORD_W-1:0] rd_data;
	logic              rd_hold;
	logic              wr_req;
	logic [ADDR_W-1:0] wr_addr;
	line_u             wr_line;

	// Reference model keyed by tag and set
	logic [LINE_W-1:0] ref_lines   [bit [LINE_ADDR_W-1:0]];
	bit                ref_present [bit [LINE_ADDR_W-1:0]];

	int checks;
	int errors;
	int test_errors;	// Error count when the current test began

	l1_dcache #(
		.LRU_TIMER_W (4)
	) i_l1_dcache (
		.iCLOCK   (iCLOCK),
		.inRESET  (inRESET),
		.remove   (remove),
		.rd_req   (rd_req),
		.rd_addr  (rd_addr),
		.rd_stall (rd_stall),
		.rd_valid (rd_valid),
		.rd_hit   (rd_hit),
		.rd_data  (rd_data),
		.rd_hold  (rd_hold),
		.wr_req   (wr_req),
		.wr_addr  (wr_addr),
		.wr_line  (wr_line)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #(CLK_PERIOD/2) iCLOCK = !iCLOCK;
	end

	initial begin
		#(2 * BUDGET_ALL * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the tests did not finish", 2 * BUDGET_ALL);
		$display("STATUS: FAIL");
		$finish;
	end

	function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int set, input int word);
		return {TAG_W'(tag), SET_W'(set), WORD_SEL_W'(word), 2'b00};
	endfunction

	function automatic logic [LINE_W-1:0] random_line();
		logic [LINE_W-1:0] line;
		for (int i = 0; i < WORDS_PER_LINE; i++) begin
			line[i*WORD_W +: WORD_W] = $urandom;
		end
		return line;
	endfunction

	task automatic compare_value(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
			input string what);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name);
		$display("Test %s finished with %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic write_line(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] line);
		@(negedge iCLOCK);
		wr_req       = 1'b1;
		wr_addr      = addr;
		wr_line.flat = line;
		@(negedge iCLOCK);
		wr_req = 1'b0;
		ref_lines[addr[ADDR_W-1:OFFSET_W]]   = line;
		ref_present[addr[ADDR_W-1:OFFSET_W]] = 1'b1;
	endtask

	// Samples a quarter period after the falling edge
	task automatic wait_result(output int waited);
		waited = 0;
		#(CLK_PERIOD/4);
		while (!rd_valid && waited < WAIT_LIMIT) begin
			@(negedge iCLOCK);
			#(CLK_PERIOD/4);
			waited++;
		end
		assert (rd_valid) else begin
			errors++;
			$display("No read result within %0d cycles at time %0t", WAIT_LIMIT, $time);
		end
	endtask

	task automatic read_check(input logic [ADDR_W-1:0] addr, input int hold_cycles,
			input string what);
		logic [LINE_ADDR_W-1:0] key;
		logic                   exp_hit;
		logic [WORD_W-1:0]      exp_data;
		int                     waited;
		key      = addr[ADDR_W-1:OFFSET_W];
		exp_hit  = ref_present.exists(key);
		exp_data = '0;
		if (exp_hit) begin
			exp_data = ref_lines[key][addr[OFFSET_W-1:2]*WORD_W +: WORD_W];
		end
		@(negedge iCLOCK);
		rd_req  = 1'b1;
		rd_addr = addr;
		@(negedge iCLOCK);
		rd_req  = 1'b0;	// Accepted at the edge just passed
		rd_hold = (hold_cycles > 0);
		if (hold_cycles > 0) begin
			rd_addr = ~addr;	// Held result must not follow the address
		end
		for (int i = 0; i < hold_cycles; i++) begin
			#(CLK_PERIOD/4);
			compare_value(rd_valid, 1'b0, {what, " valid under hold"});
			compare_value(rd_stall, 1'b1, {what, " stall under hold"});
			@(negedge iCLOCK);
		end
		rd_hold = 1'b0;
		wait_result(waited);
		compare_value(waited, 0, {what, " extra latency"});
		compare_value(rd_hit, exp_hit, {what, " hit"});
		compare_value(rd_data, exp_data, {what, " data"});
	endtask

	task automatic test_cold_miss();
		#(CLK_PERIOD/4);
		compare_value(rd_valid, 1'b0, "idle valid");
		compare_value(rd_stall, 1'b0, "idle stall");
		compare_value(rd_data, '0, "idle data");
		for (int i = 0; i < 4; i++) begin
			read_check($urandom, 0, "cold read");
		end
		report_test("cold_miss");
	endtask

	task automatic test_line_words();
		write_line(make_addr('h0a5a5, 2, 0), random_line());
		write_line(make_addr('h01234, 2, 0), random_line());	// Second way of the set
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			read_check(make_addr('h0a5a5, 2, w), 0, "word read");
		end
		write_line(make_addr('h0a5a5, 2, 0), random_line());
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			read_check(make_addr('h0a5a5, 2, w), 0, "rewritten word");
		end
		read_check(make_addr('h01234, 2, 3), 0, "other way");
		report_test("line_words");
	endtask

	task automatic test_victim();
		logic [ADDR_W-1:0] line_addr [5];	// Tags A to E in set 5
		for (int i = 0; i < 5; i++) begin
			line_addr[i] = make_addr('h100 + i, 5, i);
		end
		for (int i = 0; i < 4; i++) begin
			write_line(line_addr[i], random_line());
		end
		repeat (IDLE_CYCLES) @(negedge iCLOCK);
		read_check(line_addr[0], 0, "refresh A");
		write_line(line_addr[4], random_line());
		ref_present.delete(line_addr[1][ADDR_W-1:OFFSET_W]);	// B sat lowest at status 1
		for (int i = 0; i < 5; i++) begin
			read_check(line_addr[i], 0, "victim set");
		end
		report_test("victim");
	endtask

	task automatic test_remove();
		logic [LINE_ADDR_W-1:0] gone [$];
		foreach (ref_present[k]) begin
			gone.push_back(k);
		end
		@(negedge iCLOCK);
		remove  = 1'b1;
		rd_req  = 1'b1;	// Read presented with remove is dropped
		rd_addr = {gone[0], {OFFSET_W{1'b0}}};
		@(negedge iCLOCK);
		remove = 1'b0;
		rd_req = 1'b0;
		#(CLK_PERIOD/4);
		compare_value(rd_valid, 1'b0, "read dropped by remove");
		ref_present.delete();
		foreach (gone[i]) begin
			read_check({gone[i], {OFFSET_W{1'b0}}}, 0, "after remove");
		end
		write_line({gone[0], {OFFSET_W{1'b0}}}, random_line());
		read_check({gone[0], 6'h08}, 0, "rewrite after remove");
		write_line(make_addr('h2222, 7, 0), random_line());
		read_check(make_addr('h2222, 7, 15), 0, "new line after remove");
		report_test("remove");
	endtask

	task automatic test_back_pressure();
		write_line(make_addr('h3c3c, 9, 0), random_line());
		read_check(make_addr('h3c3c, 9, 7), 5, "held hit");
		read_check(make_addr('h3c3d, 9, 0), 3, "held miss");
		report_test("back_pressure");
	endtask

	task automatic test_conflict();
		logic [ADDR_W-1:0] addr;
		logic [LINE_W-1:0] line;
		addr = make_addr('h0777, 11, 0);
		line = random_line();
		@(negedge iCLOCK);
		wr_req       = 1'b1;
		wr_addr      = addr;
		wr_line.flat = line;
		rd_req       = 1'b1;
		rd_addr      = make_addr('h0777, 11, 9);	// Same line, other word
		#(CLK_PERIOD/4);
		compare_value(rd_stall, 1'b1, "stall same line");
		@(negedge iCLOCK);
		rd_addr = make_addr('h0777, 12, 9);
		#(CLK_PERIOD/4);
		compare_value(rd_stall, 1'b0, "stall other set");
		@(negedge iCLOCK);
		rd_addr = make_addr('h0778, 11, 9);
		#(CLK_PERIOD/4);
		compare_value(rd_stall, 1'b0, "stall other tag");
		@(negedge iCLOCK);
		rd_req = 1'b0;
		wr_req = 1'b0;
		ref_lines[addr[ADDR_W-1:OFFSET_W]]   = line;
		ref_present[addr[ADDR_W-1:OFFSET_W]] = 1'b1;
		read_check(make_addr('h0777, 11, 9), 0, "line written under conflict");
		report_test("conflict");
	endtask

	initial begin
		void'($urandom(32'he5c1_ff0f));
		checks      = 0;
		errors      = 0;
		test_errors = 0;
		inRESET     = 1'b0;
		remove      = 1'b0;
		rd_req      = 1'b0;
		rd_addr     = '0;
		rd_hold     = 1'b0;
		wr_req      = 1'b0;
		wr_addr     = '0;
		wr_line     = '0;
		repeat (RESET_CYCLES) @(negedge iCLOCK);
		inRESET = 1'b1;
		test_cold_miss();
		test_line_words();
		test_victim();
		test_remove();
		test_back_pressure();
		test_conflict();
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: sim.f
common/dcache_cfg_pkg.sv
common/dcache_types_pkg.sv
dcache/dcache_tag_store.sv
dcache/dcache_way_ram.sv
dcache/dcache_read_port.sv
dcache/l1_dcache.sv
bench/l1_dcache_sva.sv
bench/tb_l1_dcache.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the L1 data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_l1_dcache -f sim.f --Mdir "$OBJ_DIR" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$OBJ_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
	echo "Failures found in $LOG"
	exit 1
fi

exit 0
